// File: build.f
+incdir+sim
verilog/ascon_pkg.sv
verilog/ascon_round.sv
verilog/ascon_perm.sv
verilog/ct_absorb.sv
verilog/ascon_ct_decrypt.sv
sim/tb_ascon_ct.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for the fail line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_ascon_ct \
   -Mdir obj_dir -o tb_ascon_ct -f build.f > build.log 2>&1 \
   || { cat build.log; echo "Compile failed"; exit 1; }
./obj_dir/tb_ascon_ct > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log || exit 1

// File: sim/ascon_model.svh
`ifndef ASCON_MODEL_SVH
`define ASCON_MODEL_SVH

//////////////////////////////////////////////////
// Permutation model
//////////////////////////////////////////////////

function automatic logic [63:0] rotr64(input logic [63:0] v, input int n);
   return (v >> n) | (v << (64 - n));
endfunction

// Six rounds in the in-place form of the cipher spec
function automatic logic [319:0] model_permute(input logic [319:0] s);
   logic [63:0] x [0:4];
   logic [63:0] t [0:4];
   logic [7:0]  rc;
   int          i;
   int          r;
   for (i = 0; i < 5; i++) begin
      x[i] = s[319 - 64 * i -: 64];
   end
   for (r = 0; r < ascon_pkg::ROUNDS; r++) begin
      rc = 8'h96 - 8'(15 * r);
      x[2] = x[2] ^ {56'd0, rc};
      x[0] = x[0] ^ x[4];
      x[4] = x[4] ^ x[3];
      x[2] = x[2] ^ x[1];
      for (i = 0; i < 5; i++) begin
         t[i] = ~x[i] & x[(i + 1) % 5];
      end
      for (i = 0; i < 5; i++) begin
         x[i] = x[i] ^ t[(i + 1) % 5];
      end
      x[1] = x[1] ^ x[0];
      x[0] = x[0] ^ x[4];
      x[3] = x[3] ^ x[2];
      x[2] = ~x[2];
      x[0] = x[0] ^ rotr64(x[0], 19) ^ rotr64(x[0], 28);
      x[1] = x[1] ^ rotr64(x[1], 61) ^ rotr64(x[1], 39);
      x[2] = x[2] ^ rotr64(x[2], 1) ^ rotr64(x[2], 6);
      x[3] = x[3] ^ rotr64(x[3], 10) ^ rotr64(x[3], 17);
      x[4] = x[4] ^ rotr64(x[4], 7) ^ rotr64(x[4], 41);
   end
   return {x[0], x[1], x[2], x[3], x[4]};
endfunction

//////////////////////////////////////////////////
// Block walk model working one byte at a time
//////////////////////////////////////////////////

function automatic void model_decrypt(input logic [255:0] ct, input int len,
                                      input logic [319:0] st_in,
                                      output logic [255:0] pt, output logic [319:0] st_out);
   logic [319:0] s;
   logic [7:0]   cb;
   int           nfull;
   int           rem;
   int           i;
   int           j;
   int           lb;
   s     = st_in;
   pt    = '0;
   nfull = len / 8;
   rem   = len % 8;
   for (i = 0; i < nfull; i++) begin
      for (j = 0; j < 8; j++) begin
         cb = ct[64 * i + 8 * j +: 8];
         pt[64 * i + 8 * j +: 8] = cb ^ s[256 + 8 * j +: 8];
         s[256 + 8 * j +: 8] = cb;
      end
      s = model_permute(s);
   end
   // Partial bytes land in the top of the rate lane
   for (j = 0; j < rem; j++) begin
      lb = j + 8 - rem;
      cb = ct[64 * nfull + 8 * j +: 8];
      pt[64 * nfull + 8 * j +: 8] = cb ^ s[256 + 8 * lb +: 8];
      s[256 + 8 * lb +: 8] = cb;
   end
   s[256 + 8 * (7 - rem) +: 8] = s[256 + 8 * (7 - rem) +: 8] ^ ascon_pkg::PAD_BYTE;
   st_out = s;
endfunction

`endif

// File: sim/tb_ascon_ct.sv
module tb_ascon_ct;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_RANDOM  = 200;
   localparam int NUM_TX      = NUM_RANDOM + 6;
   localparam int MAX_LATENCY = 30;
   localparam int MAX_GAP     = 7;
   // Drive cycle plus trailing pulse check per request
   localparam int TIMEOUT_CYCLES = NUM_TX * (MAX_LATENCY + MAX_GAP + 2) + 100;

   logic                  clk;
   logic                  rst;
   logic                  start;
   ascon_pkg::ct_req_t    req;
   logic                  busy;
   logic                  done;
   ascon_pkg::ct_result_t result;

   logic [31:0] lfsr;
   int          cycle_count;

   ascon_ct_decrypt uut (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .req    (req),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   `include "ascon_model.svh"

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [319:0] random_state();
      logic [319:0] s;
      int           i;
      for (i = 0; i < 5; i++) begin
         s[64 * i +: 64] = take_bits(64);
      end
      return s;
   endfunction

   function automatic logic [255:0] random_ct();
      logic [255:0] c;
      int           i;
      for (i = 0; i < 4; i++) begin
         c[64 * i +: 64] = take_bits(64);
      end
      return c;
   endfunction

   task automatic check_value(input string name, input logic [319:0] got,
                              input logic [319:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   task automatic idle_gap(input int cycles);
      repeat (cycles) @(posedge clk);
   endtask

   //////////////////////////////////////////////////
   // One request with latency and pulse checks
   //////////////////////////////////////////////////

   task automatic run_request(input logic [255:0] ct, input logic [5:0] len,
                              input logic [319:0] st, input bit intrude);
      ascon_pkg::ct_req_t r;
      ascon_pkg::ct_req_t alt;
      logic [255:0]       exp_pt;
      logic [319:0]       exp_st;
      int                 exp_lat;
      int                 n;
      model_decrypt(ct, int'(len), st, exp_pt, exp_st);
      exp_lat       = 2 + 7 * (int'(len) / 8);
      r.ct          = ct;
      r.len         = len;
      r.state.raw   = st;
      alt.ct        = ~ct;
      alt.len       = 6'd5;
      alt.state.raw = ~st;
      @(posedge clk);
      start <= 1'b1;
      req   <= r;
      // Edge that samples start
      @(posedge clk);
      start <= 1'b0;
      n = 0;
      @(negedge clk);
      check_value("busy", busy, 1'b1);
      while (!done) begin
         @(posedge clk);
         n = n + 1;
         if (intrude && n == 2) begin
            start <= 1'b1;
            req   <= alt;
         end else begin
            start <= 1'b0;
         end
         @(negedge clk);
         if (!done) begin
            check_value("busy", busy, 1'b1);
         end
      end
      check_value("latency", n, exp_lat);
      check_value("busy", busy, 1'b0);
      check_value("result.pt", result.pt, exp_pt);
      check_value("result.state", result.state.raw, exp_st);
      @(negedge clk);
      check_value("done", done, 1'b0);
      check_value("busy", busy, 1'b0);
      check_value("result.pt", result.pt, exp_pt);
      check_value("result.state", result.state.raw, exp_st);
   endtask

   //////////////////////////////////////////////////
   // Scenarios
   //////////////////////////////////////////////////

   initial begin : scenarios
      logic [319:0] st;
      logic [255:0] ct;
      logic [5:0]   len;
      int           k;
      clk         = 1'b0;
      rst         = 1'b0;
      start       = 1'b0;
      req         = '0;
      lfsr        = 32'd67;
      cycle_count = 0;

      repeat (2) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      check_value("busy", busy, 1'b0);
      check_value("done", done, 1'b0);
      check_value("result.pt", result.pt, '0);
      check_value("result.state", result.state.raw, '0);

      // Empty ciphertext pads the top byte only
      st = random_state();
      ct = random_ct();
      run_request(ct, 6'd0, st, 1'b0);
      check_value("result.pt", result.pt, '0);
      check_value("result.state", result.state.raw, st ^ {8'h80, 312'd0});

      // Padding right after a permutation
      for (k = 1; k <= 4; k++) begin
         run_request(random_ct(), 6'(8 * k), random_state(), 1'b0);
      end

      for (k = 0; k < NUM_RANDOM; k++) begin
         st  = random_state();
         ct  = random_ct();
         len = 6'(take_bits(8) % 33);
         run_request(ct, len, st, 1'b0);
         idle_gap(int'(take_bits(3)));
      end

      // Second start while busy must be dropped
      run_request(random_ct(), 6'd24, random_state(), 1'b1);

      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: verilog/ascon_ct_decrypt.sv
module ascon_ct_decrypt (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  ascon_pkg::ct_req_t    req,
   output logic                  busy,
   output logic                  done,
   output ascon_pkg::ct_result_t result
);

   logic [ascon_pkg::FSM_W-1:0] fsm;

   // Captured request; its state field is the working state
   ascon_pkg::ct_req_t work_q;

   logic [ascon_pkg::BIDX_W-1:0] idx;
   logic [ascon_pkg::BIDX_W-1:0] full_blocks;

   logic [ascon_pkg::NUM_BLOCKS-1:0][ascon_pkg::LANE_W-1:0] acc;
   logic [ascon_pkg::NUM_BLOCKS-1:0][ascon_pkg::LANE_W-1:0] ct_blocks;

   logic [ascon_pkg::LANE_W-1:0] cur_block;
   logic [ascon_pkg::LANE_W-1:0] pt_block;
   logic [ascon_pkg::LANE_W-1:0] new_lane;
   logic [3:0]                   nbytes;

   ascon_pkg::state_t st_abs;
   ascon_pkg::state_t perm_out;

   logic accept;
   logic full_block;
   logic perm_start;
   logic perm_done;

   assign busy   = (fsm != ascon_pkg::ST_IDLE);
   assign accept = start && !busy;

   //////////////////////////////////////////////////
   // Current block
   //////////////////////////////////////////////////

   assign ct_blocks   = work_q.ct;
   assign full_blocks = work_q.len[ascon_pkg::LEN_W-1:3];
   assign full_block  = (idx < full_blocks);
   assign nbytes      = full_block ? 4'(ascon_pkg::BLOCK_BYTES) : {1'b0, work_q.len[2:0]};

   // Index past the last slot only occurs with nbytes zero
   assign cur_block = ct_blocks[idx[ascon_pkg::BIDX_W-2:0]];

   ct_absorb u_absorb (
      .lane_in  (work_q.state.lanes.x0),
      .block    (cur_block),
      .nbytes   (nbytes),
      .pt_block (pt_block),
      .lane_out (new_lane)
   );

   always_comb begin
      st_abs.raw      = work_q.state.raw;
      st_abs.lanes.x0 = new_lane;
   end

   assign perm_start = (fsm == ascon_pkg::ST_ABSORB) && full_block;

   ascon_perm u_perm (
      .clk        (clk),
      .rst        (rst),
      .perm_start (perm_start),
      .perm_in    (st_abs),
      .perm_done  (perm_done),
      .perm_out   (perm_out)
   );

   //////////////////////////////////////////////////
   // Block walk FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         fsm    <= ascon_pkg::ST_IDLE;
         idx    <= '0;
         done   <= 1'b0;
         result <= '0;
      end else begin
         done <= 1'b0;
         case (fsm)
            ascon_pkg::ST_IDLE: begin
               if (accept) begin
                  fsm <= ascon_pkg::ST_ABSORB;
                  idx <= '0;
               end
            end
            ascon_pkg::ST_ABSORB: begin
               if (full_block) begin
                  fsm <= ascon_pkg::ST_PERMUTE;
                  idx <= idx + 1'b1;
               end else begin
                  fsm <= ascon_pkg::ST_FINISH;
               end
            end
            ascon_pkg::ST_PERMUTE: begin
               if (perm_done) begin
                  fsm <= ascon_pkg::ST_ABSORB;
               end
            end
            ascon_pkg::ST_FINISH: begin
               result.pt    <= acc;
               result.state <= work_q.state;
               done         <= 1'b1;
               fsm          <= ascon_pkg::ST_IDLE;
            end
            default: fsm <= ascon_pkg::ST_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Working state and plaintext accumulator
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (accept) begin
         work_q <= req;
         acc    <= '0;
      end else if (fsm == ascon_pkg::ST_ABSORB) begin
         if (!idx[ascon_pkg::BIDX_W-1]) begin
            acc[idx[ascon_pkg::BIDX_W-2:0]] <= pt_block;
         end
         // Full blocks hand the absorbed state to the permutation instead
         if (!full_block) begin
            work_q.state <= st_abs;
         end
      end else if (fsm == ascon_pkg::ST_PERMUTE && perm_done) begin
         work_q.state <= perm_out;
      end
   end

   a_len_range : assert property (
      @(posedge clk) disable iff (!rst) accept |-> (req.len <= ascon_pkg::MAX_CT_BYTES)
   );

   a_done_idle_perm : assert property (
      @(posedge clk) disable iff (!rst) done |-> !u_perm.running
   );

endmodule

// File: verilog/ascon_perm.sv
module ascon_perm (
   input  logic              clk,
   input  logic              rst,
   input  logic              perm_start,
   input  ascon_pkg::state_t perm_in,
   output logic              perm_done,
   output ascon_pkg::state_t perm_out
);

   ascon_pkg::state_t st_q;
   ascon_pkg::state_t round_in;
   ascon_pkg::state_t round_out;

   logic [ascon_pkg::RND_W-1:0] rnd;
   logic                        running;
   logic                        last_round;

   // First round works straight off the input
   assign round_in   = perm_start ? perm_in : st_q;
   assign last_round = running && (rnd == ascon_pkg::RND_W'(ascon_pkg::ROUNDS - 1));

   ascon_round u_round (
      .state_in  (round_in),
      .rc        (ascon_pkg::ROUND_CONST[rnd]),
      .state_out (round_out)
   );

   //////////////////////////////////////////////////
   // Round counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         running   <= 1'b0;
         rnd       <= '0;
         perm_done <= 1'b0;
      end else begin
         perm_done <= last_round;
         if (perm_start) begin
            running <= 1'b1;
            rnd     <= ascon_pkg::RND_W'(1);
         end else if (last_round) begin
            running <= 1'b0;
            rnd     <= '0;
         end else if (running) begin
            rnd <= rnd + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (perm_start || running) begin
         st_q <= round_out;
      end
   end

   // Holds the final state once perm_done fires
   assign perm_out = st_q;

   // Controller must wait for perm_done before the next block
   a_no_restart : assert property (
      @(posedge clk) disable iff (!rst) perm_start |-> !running
   );

endmodule

// File: verilog/ascon_pkg.sv
package ascon_pkg;

   //////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////

   localparam int STATE_W      = 320;
   localparam int LANE_W       = 64;
   localparam int BLOCK_BYTES  = 8;
   localparam int MAX_CT_BYTES = 32;
   localparam int CT_W         = MAX_CT_BYTES * 8;
   localparam int NUM_BLOCKS   = MAX_CT_BYTES / BLOCK_BYTES;
   localparam int LEN_W        = 6;
   // One extra bit so the index can step past the last full block
   localparam int BIDX_W       = $clog2(NUM_BLOCKS) + 1;

   //////////////////////////////////////////////////
   // Permutation constants
   //////////////////////////////////////////////////

   localparam int ROUNDS = 6;
   localparam int RND_W  = $clog2(ROUNDS);

   // Entry 0 is the first round
   localparam logic [ROUNDS-1:0][7:0] ROUND_CONST = {
      8'h4b, 8'h5a, 8'h69, 8'h78, 8'h87, 8'h96
   };

   localparam logic [7:0] PAD_BYTE = 8'h80;

   // Block walk FSM encoding
   localparam int FSM_W = 2;
   localparam logic [FSM_W-1:0] ST_IDLE    = 2'd0;
   localparam logic [FSM_W-1:0] ST_ABSORB  = 2'd1;
   localparam logic [FSM_W-1:0] ST_PERMUTE = 2'd2;
   localparam logic [FSM_W-1:0] ST_FINISH  = 2'd3;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   // x0 is the rate lane and sits at the top
   typedef struct packed {
      logic [LANE_W-1:0] x0;
      logic [LANE_W-1:0] x1;
      logic [LANE_W-1:0] x2;
      logic [LANE_W-1:0] x3;
      logic [LANE_W-1:0] x4;
   } lanes_t;

   typedef union packed {
      logic [STATE_W-1:0] raw;
      lanes_t             lanes;
   } state_t;

   typedef struct packed {
      logic [CT_W-1:0]  ct;
      logic [LEN_W-1:0] len;
      state_t           state;
   } ct_req_t;

   typedef struct packed {
      logic [CT_W-1:0] pt;
      state_t          state;
   } ct_result_t;

endpackage

// File: verilog/ascon_round.sv
module ascon_round (
   input  ascon_pkg::state_t state_in,
   input  logic [7:0]        rc,
   output ascon_pkg::state_t state_out
);

   // Rotate right by two amounts and fold into the lane
   function automatic logic [63:0] diffuse(input logic [63:0] x, input int r0, input int r1);
      logic [63:0] rot0;
      logic [63:0] rot1;
      rot0 = (x >> r0) | (x << (64 - r0));
      rot1 = (x >> r1) | (x << (64 - r1));
      return x ^ rot0 ^ rot1;
   endfunction

   logic [63:0] a0, a1, a2, a3, a4;
   logic [63:0] b0, b1, b2, b3, b4;
   logic [63:0] c0, c1, c2, c3, c4;

   // Constant addition plus the S-box input mixing
   assign a0 = state_in.lanes.x0 ^ state_in.lanes.x4;
   assign a1 = state_in.lanes.x1;
   assign a2 = state_in.lanes.x2 ^ {56'd0, rc} ^ state_in.lanes.x1;
   assign a3 = state_in.lanes.x3;
   assign a4 = state_in.lanes.x4 ^ state_in.lanes.x3;

   // Chi-like core of the bitsliced S-box
   assign b0 = a0 ^ (~a1 & a2);
   assign b1 = a1 ^ (~a2 & a3);
   assign b2 = a2 ^ (~a3 & a4);
   assign b3 = a3 ^ (~a4 & a0);
   assign b4 = a4 ^ (~a0 & a1);

   // S-box output mixing
   assign c0 = b0 ^ b4;
   assign c1 = b1 ^ b0;
   assign c2 = ~b2;
   assign c3 = b3 ^ b2;
   assign c4 = b4;

   //////////////////////////////////////////////////
   // Linear diffusion
   //////////////////////////////////////////////////

   assign state_out.lanes.x0 = diffuse(c0, 19, 28);
   assign state_out.lanes.x1 = diffuse(c1, 61, 39);
   assign state_out.lanes.x2 = diffuse(c2, 1, 6);
   assign state_out.lanes.x3 = diffuse(c3, 10, 17);
   assign state_out.lanes.x4 = diffuse(c4, 7, 41);

endmodule

// File: verilog/ct_absorb.sv
module ct_absorb (
   input  logic [ascon_pkg::LANE_W-1:0] lane_in,
   input  logic [ascon_pkg::LANE_W-1:0] block,
   input  logic [3:0]                   nbytes,
   output logic [ascon_pkg::LANE_W-1:0] pt_block,
   output logic [ascon_pkg::LANE_W-1:0] lane_out
);

   // Lane bytes below the taken ones
   logic [3:0] gap;
   logic [6:0] gap_bits;

   logic [ascon_pkg::LANE_W-1:0] take_mask;
   logic [ascon_pkg::LANE_W-1:0] blk_aligned;
   logic [ascon_pkg::LANE_W-1:0] pad_word;
   logic [ascon_pkg::LANE_W-1:0] pad;
   logic [ascon_pkg::LANE_W-1:0] mixed;

   assign gap      = 4'(ascon_pkg::BLOCK_BYTES) - nbytes;
   assign gap_bits = {gap, 3'b000};

   //////////////////////////////////////////////////
   // Byte alignment
   //////////////////////////////////////////////////

   // Low bytes of the block line up with the top of the lane
   assign blk_aligned = block << gap_bits;

   // Shift by the full lane width clears the mask
   assign take_mask = {ascon_pkg::LANE_W{1'b1}} << gap_bits;

   // Pad byte goes just under the last taken byte
   assign pad_word = {{(ascon_pkg::LANE_W - 8){1'b0}}, ascon_pkg::PAD_BYTE};
   assign pad      = (nbytes < 4'(ascon_pkg::BLOCK_BYTES)) ?
                     (pad_word << (gap_bits - 7'd8)) : '0;

   //////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////

   assign mixed = blk_aligned ^ lane_in;

   // Back to the ciphertext byte positions with zeros from nbytes up
   assign pt_block = (mixed & take_mask) >> gap_bits;

   assign lane_out = ((lane_in & ~take_mask) | (blk_aligned & take_mask)) ^ pad;

endmodule
